// ==== common/ccu_pkg.sv ====
// CCU widths, address/word/line types and the writeback state enum, referenced by scoped name
`default_nettype none

package ccu_pkg;

    // Address and word sizes
    localparam int ADDR_WIDTH   = 32;
    localparam int DATA_WIDTH   = 32;
    localparam int WORD_BYTES   = DATA_WIDTH / 8;

    // Cache line geometry
    localparam int LINE_SIZE    = 16;
    localparam int LINE_WIDTH   = LINE_SIZE * 8;
    localparam int OFFSET_WIDTH = $clog2(LINE_SIZE);
    localparam int LINE_BEATS   = LINE_SIZE / WORD_BYTES;

    typedef logic [ADDR_WIDTH-1:0]              addr_t;
    typedef logic [ADDR_WIDTH-OFFSET_WIDTH-1:0] line_addr_t;
    typedef logic [OFFSET_WIDTH-1:0]            offset_t;
    typedef logic [DATA_WIDTH-1:0]              data_t;
    typedef logic [WORD_BYTES-1:0]              byte_sel_t;
    // Byte 0 of the line sits in bits 7:0
    typedef logic [LINE_WIDTH-1:0]              line_t;
    typedef logic [$clog2(LINE_BEATS)-1:0]      beat_t;

    typedef enum logic {WB_IDLE, WB_SEND} wb_state_t;

endpackage

`default_nettype wire

// ==== common/vq_pkg.sv ====
// Victim queue depth and the index, pointer and entry-mask types, referenced by scoped name
`default_nettype none

package vq_pkg;

    localparam int VQ_DEPTH     = 4;
    localparam int VQ_IDX_WIDTH = $clog2(VQ_DEPTH);

    // Entry index into the queue
    typedef logic [VQ_IDX_WIDTH-1:0] vq_idx_t;

    // Index with an extra wrap bit on top
    typedef logic [VQ_IDX_WIDTH:0]   vq_ptr_t;

    // One bit per entry
    typedef logic [VQ_DEPTH-1:0]     vq_mask_t;

endpackage

`default_nettype wire

// ==== src/vq/vq_entry.sv ====
// Single victim queue entry with valid bit, stored line and line-address compare for lookups
`timescale 1ns/1ps
`default_nettype none

module vq_entry (
    input  wire logic                 clk,
    input  wire logic                 i_rst_n,

    // Allocation from the victim strobe
    input  wire logic                 i_alloc_en,
    input  wire ccu_pkg::line_addr_t  i_alloc_line_addr,
    input  wire ccu_pkg::line_t       i_alloc_data,

    // Release once the line has been written back
    input  wire logic                 i_free,

    // Lookup compare
    input  wire ccu_pkg::line_addr_t  i_lookup_line_addr,
    output logic                      o_lookup_hit,

    // Stored contents
    output logic                      o_valid,
    output ccu_pkg::line_addr_t       o_line_addr,
    output ccu_pkg::line_t            o_data
);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (i_alloc_en) begin
            o_valid <= 1'b1;
        end else if (i_free) begin
            o_valid <= 1'b0;
        end
    end

    // Payload only changes on allocation
    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            o_line_addr <= i_alloc_line_addr;
            o_data      <= i_alloc_data;
        end
    end

    assign o_lookup_hit = o_valid && (o_line_addr == i_lookup_line_addr);

endmodule

`default_nettype wire

// ==== src/vq/vq_queue_ctrl.sv ====
// Head and tail pointer control for the victim queue, with wrap bits to tell full from empty
`timescale 1ns/1ps
`default_nettype none

module vq_queue_ctrl (
    input  wire logic            clk,
    input  wire logic            i_rst_n,

    // Advance requests
    input  wire logic            i_incr_head,
    input  wire logic            i_incr_tail,

    // Entry indices without the wrap bit
    output vq_pkg::vq_idx_t      o_head,
    output vq_pkg::vq_idx_t      o_tail,

    output logic                 o_full
);

    localparam int IDX_MSB = vq_pkg::VQ_IDX_WIDTH - 1;

    vq_pkg::vq_ptr_t head_ptr;
    vq_pkg::vq_ptr_t tail_ptr;

    // Oldest entry, moved on when its writeback completes
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            head_ptr <= '0;
        end else if (i_incr_head) begin
            head_ptr <= head_ptr + vq_pkg::vq_ptr_t'(1);
        end
    end

    // Next free slot, moved on per accepted victim
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tail_ptr <= '0;
        end else if (i_incr_tail) begin
            tail_ptr <= tail_ptr + vq_pkg::vq_ptr_t'(1);
        end
    end

    assign o_head = head_ptr[IDX_MSB:0];
    assign o_tail = tail_ptr[IDX_MSB:0];

    // Same slot but one lap apart means every entry is in use
    assign o_full = (head_ptr[IDX_MSB:0] == tail_ptr[IDX_MSB:0]) &&
                    (head_ptr[vq_pkg::VQ_IDX_WIDTH] != tail_ptr[vq_pkg::VQ_IDX_WIDTH]);

endmodule

`default_nettype wire

// ==== src/vq/vq_lookup.sv ====
// Lookup result stage that picks the selected bytes out of the hit line and registers hit and data
`timescale 1ns/1ps
`default_nettype none

module vq_lookup (
    input  wire logic                clk,
    input  wire logic                i_rst_n,

    // Lookup request for this cycle
    input  wire logic                i_lookup_valid,
    input  wire ccu_pkg::offset_t    i_offset,
    input  wire ccu_pkg::byte_sel_t  i_byte_sel,

    // Entry compare results and the matching line
    input  wire vq_pkg::vq_mask_t    i_hit_mask,
    input  wire ccu_pkg::line_t      i_hit_line,

    // Registered result, one cycle after the strobe
    output logic                     o_hit,
    output ccu_pkg::data_t           o_data
);

    logic            lookup_hit;
    ccu_pkg::line_t  shifted_line;
    ccu_pkg::data_t  lookup_data;

    assign lookup_hit = i_lookup_valid && (|i_hit_mask);

    // Move the addressed byte down to bit 0
    // Bytes past the end of the line shift in as zero, which gives the clipping for free
    assign shifted_line = i_hit_line >> {i_offset, 3'b000};

    always_comb begin
        lookup_data = '0;
        for (int j = 0; j < ccu_pkg::WORD_BYTES; j++) begin
            if (i_byte_sel[j]) begin
                lookup_data[j*8 +: 8] = shifted_line[j*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hit  <= 1'b0;
            o_data <= '0;
        end else begin
            o_hit  <= lookup_hit;
            // Data on a miss is don't-care
            o_data <= lookup_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/vq/ccu_vq.sv ====
// Victim queue holding evicted lines, serving load lookups and presenting the oldest line for writeback
`timescale 1ns/1ps
`default_nettype none

module ccu_vq (
    input  wire logic                clk,
    input  wire logic                i_rst_n,

    // Victim enqueue
    input  wire logic                i_vq_victim_valid,
    input  wire ccu_pkg::addr_t      i_vq_victim_addr,
    input  wire ccu_pkg::line_t      i_vq_victim_data,

    // Load lookup
    input  wire logic                i_vq_lookup_valid,
    input  wire ccu_pkg::addr_t      i_vq_lookup_addr,
    input  wire ccu_pkg::byte_sel_t  i_vq_lookup_byte_sel,
    output logic                     o_vq_lookup_hit,
    output ccu_pkg::data_t           o_vq_lookup_data,

    output logic                     o_vq_full,

    // Writeback request, held until done
    input  wire logic                i_ccu_done,
    output logic                     o_ccu_en,
    output ccu_pkg::addr_t           o_ccu_addr,
    output ccu_pkg::line_t           o_ccu_data
);

    vq_pkg::vq_idx_t      head;
    vq_pkg::vq_idx_t      tail;
    logic                 queue_full;

    vq_pkg::vq_mask_t     alloc_en;
    vq_pkg::vq_mask_t     free_en;
    vq_pkg::vq_mask_t     hit_mask;
    vq_pkg::vq_mask_t     entry_valid;
    vq_pkg::vq_idx_t      hit_idx;

    ccu_pkg::line_addr_t  victim_line_addr;
    ccu_pkg::line_addr_t  lookup_line_addr;
    ccu_pkg::offset_t     lookup_offset;

    ccu_pkg::line_addr_t  entry_line_addr [vq_pkg::VQ_DEPTH];
    ccu_pkg::line_t       entry_data      [vq_pkg::VQ_DEPTH];

    assign victim_line_addr = i_vq_victim_addr[ccu_pkg::ADDR_WIDTH-1:ccu_pkg::OFFSET_WIDTH];
    assign lookup_line_addr = i_vq_lookup_addr[ccu_pkg::ADDR_WIDTH-1:ccu_pkg::OFFSET_WIDTH];
    assign lookup_offset    = i_vq_lookup_addr[ccu_pkg::OFFSET_WIDTH-1:0];

    // Tail slot takes the victim unless the queue is already full
    // Done frees whatever sits at the head
    always_comb begin
        alloc_en = '0;
        free_en  = '0;
        alloc_en[tail] = i_vq_victim_valid && !queue_full;
        free_en[head]  = i_ccu_done;
    end

    for (genvar i = 0; i < vq_pkg::VQ_DEPTH; i++) begin : gen_entry
        vq_entry u_entry (
            .clk                (clk),
            .i_rst_n            (i_rst_n),
            .i_alloc_en         (alloc_en[i]),
            .i_alloc_line_addr  (victim_line_addr),
            .i_alloc_data       (i_vq_victim_data),
            .i_free             (free_en[i]),
            .i_lookup_line_addr (lookup_line_addr),
            .o_lookup_hit       (hit_mask[i]),
            .o_valid            (entry_valid[i]),
            .o_line_addr        (entry_line_addr[i]),
            .o_data             (entry_data[i])
        );
    end

    vq_queue_ctrl u_queue_ctrl (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_incr_head (i_ccu_done),
        .i_incr_tail (|alloc_en),
        .o_head      (head),
        .o_tail      (tail),
        .o_full      (queue_full)
    );

    // At most one entry matches, so OR-ing the indices encodes the one-hot mask
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < vq_pkg::VQ_DEPTH; i++) begin
            if (hit_mask[i]) begin
                hit_idx = hit_idx | vq_pkg::vq_idx_t'(i);
            end
        end
    end

    vq_lookup u_lookup (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_lookup_valid (i_vq_lookup_valid),
        .i_offset       (lookup_offset),
        .i_byte_sel     (i_vq_lookup_byte_sel),
        .i_hit_mask     (hit_mask),
        .i_hit_line     (entry_data[hit_idx]),
        .o_hit          (o_vq_lookup_hit),
        .o_data         (o_vq_lookup_data)
    );

    // Head entry is the writeback request
    assign o_ccu_en   = entry_valid[head];
    assign o_ccu_addr = {entry_line_addr[head], {ccu_pkg::OFFSET_WIDTH{1'b0}}};
    assign o_ccu_data = entry_data[head];

    assign o_vq_full = queue_full;

endmodule

`default_nettype wire

// ==== src/ccu_writeback.sv ====
// Writeback engine that streams a held cache line to the memory write port one word per beat
`timescale 1ns/1ps
`default_nettype none

module ccu_writeback (
    input  wire logic            clk,
    input  wire logic            i_rst_n,

    // Line request from the victim queue
    input  wire logic            i_ccu_en,
    input  wire ccu_pkg::addr_t  i_ccu_addr,
    input  wire ccu_pkg::line_t  i_ccu_data,
    output logic                 o_ccu_done,

    // Memory write port, one strobe per beat
    output logic                 o_mem_wr_valid,
    output ccu_pkg::addr_t       o_mem_wr_addr,
    output ccu_pkg::data_t       o_mem_wr_data
);

    localparam ccu_pkg::beat_t LAST_BEAT = ccu_pkg::beat_t'(ccu_pkg::LINE_BEATS - 1);

    ccu_pkg::wb_state_t  state;
    ccu_pkg::wb_state_t  state_next;
    ccu_pkg::beat_t      beat;
    logic                last_beat;

    assign last_beat = (beat == LAST_BEAT);

    always_comb begin
        state_next = state;
        case (state)
            ccu_pkg::WB_IDLE: begin
                if (i_ccu_en) begin
                    state_next = ccu_pkg::WB_SEND;
                end
            end
            ccu_pkg::WB_SEND: begin
                if (last_beat) begin
                    state_next = ccu_pkg::WB_IDLE;
                end
            end
            default: state_next = ccu_pkg::WB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ccu_pkg::WB_IDLE;
            beat  <= '0;
        end else begin
            state <= state_next;
            // Counter wraps back to zero after the last beat
            if (state == ccu_pkg::WB_SEND) begin
                beat <= beat + ccu_pkg::beat_t'(1);
            end else begin
                beat <= '0;
            end
        end
    end

    // The queue holds addr and data steady until done, so slice them directly
    assign o_mem_wr_valid = (state == ccu_pkg::WB_SEND);
    assign o_mem_wr_addr  = i_ccu_addr + (ccu_pkg::addr_t'(beat) << 2);
    assign o_mem_wr_data  = i_ccu_data[beat*ccu_pkg::DATA_WIDTH +: ccu_pkg::DATA_WIDTH];

    // Done rides along with the final beat
    assign o_ccu_done = o_mem_wr_valid && last_beat;

endmodule

`default_nettype wire

// ==== src/ccu_vq_top.sv ====
// Top level joining the victim queue to the writeback engine and its memory write port
`timescale 1ns/1ps
`default_nettype none

module ccu_vq_top (
    input  wire logic                clk,
    input  wire logic                i_rst_n,

    // Victim enqueue
    input  wire logic                i_vq_victim_valid,
    input  wire ccu_pkg::addr_t      i_vq_victim_addr,
    input  wire ccu_pkg::line_t      i_vq_victim_data,

    // Load lookup
    input  wire logic                i_vq_lookup_valid,
    input  wire ccu_pkg::addr_t      i_vq_lookup_addr,
    input  wire ccu_pkg::byte_sel_t  i_vq_lookup_byte_sel,
    output logic                     o_vq_lookup_hit,
    output ccu_pkg::data_t           o_vq_lookup_data,

    output logic                     o_vq_full,

    // Memory write port
    output logic                     o_mem_wr_valid,
    output ccu_pkg::addr_t           o_mem_wr_addr,
    output ccu_pkg::data_t           o_mem_wr_data
);

    // Queue to writeback request
    logic            ccu_en;
    logic            ccu_done;
    ccu_pkg::addr_t  ccu_addr;
    ccu_pkg::line_t  ccu_data;

    ccu_vq u_vq (
        .clk                  (clk),
        .i_rst_n              (i_rst_n),
        .i_vq_victim_valid    (i_vq_victim_valid),
        .i_vq_victim_addr     (i_vq_victim_addr),
        .i_vq_victim_data     (i_vq_victim_data),
        .i_vq_lookup_valid    (i_vq_lookup_valid),
        .i_vq_lookup_addr     (i_vq_lookup_addr),
        .i_vq_lookup_byte_sel (i_vq_lookup_byte_sel),
        .o_vq_lookup_hit      (o_vq_lookup_hit),
        .o_vq_lookup_data     (o_vq_lookup_data),
        .o_vq_full            (o_vq_full),
        .i_ccu_done           (ccu_done),
        .o_ccu_en             (ccu_en),
        .o_ccu_addr           (ccu_addr),
        .o_ccu_data           (ccu_data)
    );

    ccu_writeback u_writeback (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_ccu_en       (ccu_en),
        .i_ccu_addr     (ccu_addr),
        .i_ccu_data     (ccu_data),
        .o_ccu_done     (ccu_done),
        .o_mem_wr_valid (o_mem_wr_valid),
        .o_mem_wr_addr  (o_mem_wr_addr),
        .o_mem_wr_data  (o_mem_wr_data)
    );

endmodule

`default_nettype wire

// ==== bench/ccu_vq_props.sv ====
// Concurrent assertions on the victim queue top level, attached to ccu_vq_top by bind
`timescale 1ns/1ps
`default_nettype none

module ccu_vq_props (
    input  wire logic              clk,
    input  wire logic              i_rst_n,
    input  wire logic              i_vq_lookup_valid,
    input  wire logic              o_vq_lookup_hit,
    input  wire logic              o_mem_wr_valid,
    input  wire ccu_pkg::addr_t    o_mem_wr_addr,
    input  wire vq_pkg::vq_mask_t  i_hit_mask
);

    // Duplicate line addresses in the queue are not supported
    assert property (@(posedge clk) disable iff (!i_rst_n) $onehot0(i_hit_mask))
        else $error("more than one victim queue entry matches the lookup address");

    assert property (@(posedge clk) disable iff (!i_rst_n)
                     o_vq_lookup_hit |-> $past(i_vq_lookup_valid))
        else $error("lookup hit without a lookup strobe in the previous cycle");

    // Lines are never back to back, so adjacent beats belong to one line
    assert property (@(posedge clk) disable iff (!i_rst_n)
                     o_mem_wr_valid && $past(o_mem_wr_valid) |->
                     o_mem_wr_addr == $past(o_mem_wr_addr) + 32'd4)
        else $error("memory write address did not step by one word");

    assert property (@(posedge clk) !i_rst_n |-> !o_mem_wr_valid)
        else $error("memory write strobe active during reset");

endmodule

// Hit mask is taken from inside the victim queue
bind ccu_vq_top ccu_vq_props u_props (
    .clk               (clk),
    .i_rst_n           (i_rst_n),
    .i_vq_lookup_valid (i_vq_lookup_valid),
    .o_vq_lookup_hit   (o_vq_lookup_hit),
    .o_mem_wr_valid    (o_mem_wr_valid),
    .o_mem_wr_addr     (o_mem_wr_addr),
    .i_hit_mask        (u_vq.hit_mask)
);

`default_nettype wire

// ==== bench/ccu_vq_tb.sv ====
// Self-checking testbench for ccu_vq_top with random victims and lookups against a queue model
`timescale 1ns/1ps
`default_nettype none

module ccu_vq_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RANDOM_OPS = 400;
    localparam int NUM_OPS    = RANDOM_OPS + 100;
    localparam int TIMEOUT_NS = (NUM_OPS * 10 + 100) * CLK_PERIOD;

    logic                clk = 1'b0;
    logic                i_rst_n;
    logic                i_vq_victim_valid;
    ccu_pkg::addr_t      i_vq_victim_addr;
    ccu_pkg::line_t      i_vq_victim_data;
    logic                i_vq_lookup_valid;
    ccu_pkg::addr_t      i_vq_lookup_addr;
    ccu_pkg::byte_sel_t  i_vq_lookup_byte_sel;
    logic                o_vq_lookup_hit;
    ccu_pkg::data_t      o_vq_lookup_data;
    logic                o_vq_full;
    logic                o_mem_wr_valid;
    ccu_pkg::addr_t      o_mem_wr_addr;
    ccu_pkg::data_t      o_mem_wr_data;

    // Reference queue with the oldest line at index 0
    ccu_pkg::addr_t      model_addr [$];
    ccu_pkg::line_t      model_line [$];
    int                  beat_idx      = 0;
    logic                pend_hit      = 1'b0;
    ccu_pkg::data_t      pend_data     = '0;
    int                  victim_count  = 0;
    int                  dropped_count = 0;
    int                  hit_count     = 0;
    int                  error_count   = 0;

    ccu_vq_top DUT (
        .clk                  (clk),
        .i_rst_n              (i_rst_n),
        .i_vq_victim_valid    (i_vq_victim_valid),
        .i_vq_victim_addr     (i_vq_victim_addr),
        .i_vq_victim_data     (i_vq_victim_data),
        .i_vq_lookup_valid    (i_vq_lookup_valid),
        .i_vq_lookup_addr     (i_vq_lookup_addr),
        .i_vq_lookup_byte_sel (i_vq_lookup_byte_sel),
        .o_vq_lookup_hit      (o_vq_lookup_hit),
        .o_vq_lookup_data     (o_vq_lookup_data),
        .o_vq_full            (o_vq_full),
        .o_mem_wr_valid       (o_mem_wr_valid),
        .o_mem_wr_addr        (o_mem_wr_addr),
        .o_mem_wr_data        (o_mem_wr_data)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // Unique line base per victim number
    function automatic ccu_pkg::addr_t victim_base(input int n);
        ccu_pkg::line_addr_t line_addr;
        line_addr = ccu_pkg::line_addr_t'(32'h00A0_0000 + n * 32'h35);
        return {line_addr, {ccu_pkg::OFFSET_WIDTH{1'b0}}};
    endfunction

    // Lookup address on a recent victim, the next victim or a line that is never queued
    function automatic ccu_pkg::addr_t pick_lookup_addr();
        int             n;
        ccu_pkg::addr_t base;
        if ($urandom_range(3) == 0) begin
            base = {4'hF, 24'($urandom), 4'h0};
        end else begin
            n = victim_count - int'($urandom_range(6));
            if (n < 0) begin
                n = 0;
            end
            base = victim_base(n);
        end
        return base | ccu_pkg::addr_t'($urandom_range(15));
    endfunction

    // Expected {hit, data} for a lookup against the model as it stands
    function automatic logic [32:0] lookup_ref(input ccu_pkg::addr_t addr,
                                               input ccu_pkg::byte_sel_t sel);
        logic [32:0]    result;
        ccu_pkg::line_t entry_line;
        int             off;
        result = '0;
        off = int'(addr[ccu_pkg::OFFSET_WIDTH-1:0]);
        for (int i = 0; i < model_addr.size(); i++) begin
            if (model_addr[i][31:4] == addr[31:4]) begin
                entry_line = model_line[i];
                result[32] = 1'b1;
                for (int j = 0; j < ccu_pkg::WORD_BYTES; j++) begin
                    if (sel[j] && (off + j) < ccu_pkg::LINE_SIZE) begin
                        result[j*8 +: 8] = entry_line[(off + j)*8 +: 8];
                    end
                end
            end
        end
        return result;
    endfunction

    task automatic drive_cycle(input logic victim_en, input logic lookup_en,
                               input ccu_pkg::addr_t lookup_addr,
                               input ccu_pkg::byte_sel_t sel);
        @(posedge clk);
        #2;
        i_vq_victim_valid = victim_en;
        if (victim_en) begin
            i_vq_victim_addr = victim_base(victim_count);
            i_vq_victim_data = {$urandom, $urandom, $urandom, $urandom};
            victim_count++;
        end
        i_vq_lookup_valid    = lookup_en;
        i_vq_lookup_addr     = lookup_addr;
        i_vq_lookup_byte_sel = sel;
    endtask

    task automatic wait_drained();
        while (model_addr.size() != 0) begin
            drive_cycle(1'b0, 1'b0, '0, '0);
        end
        drive_cycle(1'b0, 1'b0, '0, '0);
    endtask

    // Outputs are compared mid-cycle once inputs and DUT state have settled
    always @(negedge clk) begin : compare
        int             count_before;
        logic [32:0]    expect_now;
        ccu_pkg::line_t head_line;
        if (!i_rst_n) begin
            check_value(32'(o_vq_full), 32'd0, "o_vq_full during reset");
            check_value(32'(o_vq_lookup_hit), 32'd0, "o_vq_lookup_hit during reset");
            check_value(32'(o_mem_wr_valid), 32'd0, "o_mem_wr_valid during reset");
        end else begin
            count_before = model_addr.size();
            check_value(32'(o_vq_full), 32'(count_before == vq_pkg::VQ_DEPTH),
                        "o_vq_full against model count");
            check_value(32'(o_vq_lookup_hit), 32'(pend_hit), "lookup hit");
            if (pend_hit) begin
                check_value(o_vq_lookup_data, pend_data, "lookup data");
            end
            // Lookup sees the entries before this edge's allocation or free
            expect_now = lookup_ref(i_vq_lookup_addr, i_vq_lookup_byte_sel);
            pend_hit  = i_vq_lookup_valid && expect_now[32];
            pend_data = expect_now[31:0];
            if (pend_hit) begin
                hit_count++;
            end
            if (o_mem_wr_valid) begin
                check_value(32'(count_before != 0), 32'd1, "memory beat with an empty model");
                head_line = model_line[0];
                check_value(o_mem_wr_addr, model_addr[0] + 32'(beat_idx * 4),
                            "memory write address");
                check_value(o_mem_wr_data, head_line[beat_idx*32 +: 32], "memory write data");
                beat_idx++;
                if (beat_idx == ccu_pkg::LINE_BEATS) begin
                    void'(model_addr.pop_front());
                    void'(model_line.pop_front());
                    beat_idx = 0;
                end
            end
            if (i_vq_victim_valid) begin
                if (count_before < vq_pkg::VQ_DEPTH) begin
                    model_addr.push_back(i_vq_victim_addr);
                    model_line.push_back(i_vq_victim_data);
                end else begin
                    dropped_count++;
                end
            end
        end
    end

    initial begin : stimulus
        ccu_pkg::addr_t base;
        void'($urandom(73361));
        i_rst_n              = 1'b0;
        i_vq_victim_valid    = 1'b0;
        i_vq_victim_addr     = '0;
        i_vq_victim_data     = '0;
        i_vq_lookup_valid    = 1'b0;
        i_vq_lookup_addr     = '0;
        i_vq_lookup_byte_sel = '0;
        repeat (3) @(posedge clk);
        #2;
        i_rst_n = 1'b1;

        // Single line whose first lookup lands in its allocation cycle
        base = victim_base(victim_count);
        drive_cycle(1'b1, 1'b1, base, 4'hF);
        drive_cycle(1'b0, 1'b1, base | 32'd6, 4'hF);
        drive_cycle(1'b0, 1'b1, base | 32'd13, 4'hF);
        drive_cycle(1'b0, 1'b1, base | 32'd14, 4'b0111);
        drive_cycle(1'b0, 1'b1, base | 32'd15, 4'b1011);
        wait_drained();
        drive_cycle(1'b0, 1'b1, base | 32'd5, 4'hF);
        drive_cycle(1'b0, 1'b1, 32'hF123_4560, 4'hF);

        // Back to back victims overrun the writeback rate
        repeat (8) drive_cycle(1'b1, 1'b1, pick_lookup_addr(), 4'($urandom));
        wait_drained();

        repeat (RANDOM_OPS) begin
            drive_cycle($urandom_range(2) == 0, $urandom_range(1) == 1,
                        pick_lookup_addr(), 4'($urandom));
        end
        wait_drained();
        drive_cycle(1'b0, 1'b0, '0, '0);

        check_value(32'(dropped_count != 0), 32'd1, "victims dropped while full");
        check_value(32'(hit_count != 0), 32'd1, "lookups that hit");

        if (error_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "checks failed");
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish in time", TIMEOUT_NS);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== compile.f ====
common/ccu_pkg.sv
common/vq_pkg.sv
src/vq/vq_entry.sv
src/vq/vq_queue_ctrl.sv
src/vq/vq_lookup.sv
src/vq/ccu_vq.sv
src/ccu_writeback.sv
src/ccu_vq_top.sv
bench/ccu_vq_props.sv
bench/ccu_vq_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
TOP        ?= ccu_vq_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
PASS_TEXT  := Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)
